/* common/cpu_pkg.sv */
`default_nettype none

`include "dcache_defs.svh"

package cpu_pkg;

	typedef logic [`DC_WORD_W-1:0] word_t;

	// byte address as the cache sees it
	typedef struct packed {
		logic [`DC_TAG_W-1:0] tag;
		logic [`DC_IDX_W-1:0] idx;
		logic [`DC_OFF_W-1:0] blkoff;
		logic [1:0] bytoff;
	} dc_addr_t;

	// levels held until hit
	typedef struct packed {
		logic ren;
		logic wen;
		logic halt;
		dc_addr_t addr;
		word_t store;
	} cpu_req_t;

	typedef struct packed {
		logic hit;
		word_t load;
		logic flushed;
	} cpu_rsp_t;

endpackage

`default_nettype wire

/* common/dcache_defs.svh */
`ifndef DCACHE_DEFS_SVH
`define DCACHE_DEFS_SVH

// cache geometry
`define DC_SETS 8
`define DC_WAYS 2
`define DC_WORDS 2

// field widths
`define DC_WORD_W 32
`define DC_IDX_W 3
`define DC_OFF_W 1

// 32 minus index, block offset and byte offset
`define DC_TAG_W 26

`endif

/* common/mem_pkg.sv */
`default_nettype none

`include "dcache_defs.svh"

package mem_pkg;

	// per-line state kept beside the data
	typedef struct packed {
		logic valid;
		logic dirty;
		logic [`DC_TAG_W-1:0] tag;
	} line_meta_t;

	// indexed by block offset
	typedef cpu_pkg::word_t [`DC_WORDS-1:0] line_data_t;

	// one word per transfer, at most one strobe high
	typedef struct packed {
		logic ren;
		logic wen;
		cpu_pkg::word_t addr;
		cpu_pkg::word_t store;
	} mem_req_t;

	// stall low completes the current word
	typedef struct packed {
		logic stall;
		cpu_pkg::word_t load;
	} mem_rsp_t;

	typedef enum logic [2:0] {
		IDLE,
		WB,
		FILL,
		FLUSH,
		DONE
	} ctrl_state_t;

endpackage

`default_nettype wire

/* dcache/cache_ctrl.sv */
`timescale 1ns/10ps
`default_nettype none

`include "dcache_defs.svh"

module cache_ctrl (
	input logic CLK,
	input logic nRST,
	input cpu_pkg::cpu_req_t req,
	output cpu_pkg::cpu_rsp_t rsp,
	output mem_pkg::mem_req_t mreq,
	input mem_pkg::mem_rsp_t mrsp,
	input logic hit,
	input logic hit_way,
	input logic victim_way,
	input mem_pkg::line_meta_t victim,
	input mem_pkg::line_data_t [`DC_WAYS-1:0] lines,
	output logic [`DC_IDX_W-1:0] ridx,
	output logic lru,
	output logic flushing,
	output logic [`DC_WAYS-1:0] meta_we,
	output logic [`DC_WAYS-1:0] data_we,
	output mem_pkg::line_meta_t meta_wdata,
	output mem_pkg::line_data_t data_wdata
);

	mem_pkg::ctrl_state_t state, next_state;
	logic [`DC_OFF_W-1:0] wcnt, next_wcnt;
	logic vway, next_vway;
	// {set, way} walked during flush
	logic [`DC_IDX_W:0] fcnt, next_fcnt;
	logic [`DC_SETS-1:0] lru_bits, next_lru_bits;

	logic fway;
	logic [`DC_IDX_W-1:0] fset;
	logic last_word;
	logic access;
	cpu_pkg::dc_addr_t maddr;

	assign fway = fcnt[0];
	assign fset = fcnt[`DC_IDX_W:1];
	assign last_word = (wcnt == `DC_OFF_W'(`DC_WORDS - 1));
	assign access = req.ren | req.wen;

	always_ff @(posedge CLK, negedge nRST) begin
		if (!nRST) begin
			state <= mem_pkg::IDLE;
			wcnt <= '0;
			vway <= 1'b0;
			fcnt <= '0;
			lru_bits <= '0;
		end else begin
			state <= next_state;
			wcnt <= next_wcnt;
			vway <= next_vway;
			fcnt <= next_fcnt;
			lru_bits <= next_lru_bits;
		end
	end

	always_comb begin
		next_state = state;
		next_wcnt = wcnt;
		next_vway = vway;
		next_fcnt = fcnt;
		next_lru_bits = lru_bits;

		ridx = req.addr.idx;
		lru = lru_bits[req.addr.idx];
		flushing = 1'b0;
		meta_we = '0;
		data_we = '0;
		meta_wdata = '0;
		data_wdata = lines[hit_way];

		// word address of the current transfer
		maddr = req.addr;
		maddr.blkoff = wcnt;
		maddr.bytoff = 2'b00;
		mreq = '0;

		rsp.hit = 1'b0;
		rsp.load = lines[hit_way][req.addr.blkoff];
		rsp.flushed = (state == mem_pkg::DONE);

		case (state)
			mem_pkg::IDLE: begin
				if (req.halt) begin
					next_state = mem_pkg::FLUSH;
					next_fcnt = '0;
					next_wcnt = '0;
				end else if (access && hit) begin
					rsp.hit = 1'b1;
					// point away from the way just used
					next_lru_bits[req.addr.idx] = ~hit_way;
					if (req.wen) begin
						meta_we[hit_way] = 1'b1;
						meta_wdata.valid = 1'b1;
						meta_wdata.dirty = 1'b1;
						meta_wdata.tag = req.addr.tag;
						data_we[hit_way] = 1'b1;
						data_wdata[req.addr.blkoff] = req.store;
					end
				end else if (access) begin
					next_vway = victim_way;
					next_wcnt = '0;
					if (victim.valid && victim.dirty) begin
						next_state = mem_pkg::WB;
					end else begin
						next_state = mem_pkg::FILL;
					end
				end
			end
			mem_pkg::WB: begin
				mreq.wen = 1'b1;
				maddr.tag = victim.tag;
				mreq.store = lines[vway][wcnt];
				if (!mrsp.stall) begin
					next_wcnt = wcnt + 1'b1;
					if (last_word) begin
						next_state = mem_pkg::FILL;
						next_wcnt = '0;
					end
				end
			end
			mem_pkg::FILL: begin
				mreq.ren = 1'b1;
				data_wdata = lines[vway];
				data_wdata[wcnt] = mrsp.load;
				if (!mrsp.stall) begin
					data_we[vway] = 1'b1;
					next_wcnt = wcnt + 1'b1;
					// line becomes valid with the last word
					if (last_word) begin
						meta_we[vway] = 1'b1;
						meta_wdata.valid = 1'b1;
						meta_wdata.dirty = 1'b0;
						meta_wdata.tag = req.addr.tag;
						next_state = mem_pkg::IDLE;
						next_wcnt = '0;
					end
				end
			end
			mem_pkg::FLUSH: begin
				ridx = fset;
				lru = fway;
				flushing = 1'b1;
				maddr.tag = victim.tag;
				maddr.idx = fset;
				mreq.store = lines[fway][wcnt];
				if (victim.valid && victim.dirty) begin
					mreq.wen = 1'b1;
					if (!mrsp.stall) begin
						next_wcnt = wcnt + 1'b1;
						if (last_word) begin
							meta_we[fway] = 1'b1;
							next_wcnt = '0;
							next_fcnt = fcnt + 1'b1;
							if (&fcnt) begin
								next_state = mem_pkg::DONE;
							end
						end
					end
				end else begin
					// clean or empty line, just invalidate
					meta_we[fway] = 1'b1;
					next_fcnt = fcnt + 1'b1;
					if (&fcnt) begin
						next_state = mem_pkg::DONE;
					end
				end
			end
			mem_pkg::DONE: begin
				next_state = mem_pkg::DONE;
			end
			default: begin
				next_state = mem_pkg::IDLE;
			end
		endcase

		mreq.addr = maddr;
	end

endmodule

`default_nettype wire

/* dcache/dcache.sv */
`timescale 1ns/10ps
`default_nettype none

`include "dcache_defs.svh"

module dcache (
	input logic CLK,
	input logic nRST,
	input cpu_pkg::cpu_req_t req,
	output cpu_pkg::cpu_rsp_t rsp,
	output mem_pkg::mem_req_t mreq,
	input mem_pkg::mem_rsp_t mrsp
);

	mem_pkg::line_meta_t [`DC_WAYS-1:0] meta;
	mem_pkg::line_data_t [`DC_WAYS-1:0] lines;
	logic [`DC_WAYS-1:0] meta_we;
	logic [`DC_WAYS-1:0] data_we;
	mem_pkg::line_meta_t meta_wdata;
	mem_pkg::line_data_t data_wdata;
	mem_pkg::line_meta_t victim;
	logic [`DC_IDX_W-1:0] ridx;
	logic hit;
	logic hit_way;
	logic victim_way;
	logic lru;
	logic flushing;

	// metadata and data storage for each way
	for (genvar w = 0; w < `DC_WAYS; w++) begin : g_way
		set_ram #(.entry_t(mem_pkg::line_meta_t)) u_meta (
			.CLK(CLK),
			.nRST(nRST),
			.we(meta_we[w]),
			.widx(ridx),
			.ridx(ridx),
			.wdata(meta_wdata),
			.rdata(meta[w])
		);

		set_ram #(.entry_t(mem_pkg::line_data_t)) u_data (
			.CLK(CLK),
			.nRST(nRST),
			.we(data_we[w]),
			.widx(ridx),
			.ridx(ridx),
			.wdata(data_wdata),
			.rdata(lines[w])
		);
	end

	tag_lookup u_lookup (
		.addr(req.addr),
		.meta(meta),
		.lru(lru),
		.flushing(flushing),
		.hit(hit),
		.hit_way(hit_way),
		.victim_way(victim_way),
		.victim(victim)
	);

	cache_ctrl u_ctrl (
		.CLK(CLK),
		.nRST(nRST),
		.req(req),
		.rsp(rsp),
		.mreq(mreq),
		.mrsp(mrsp),
		.hit(hit),
		.hit_way(hit_way),
		.victim_way(victim_way),
		.victim(victim),
		.lines(lines),
		.ridx(ridx),
		.lru(lru),
		.flushing(flushing),
		.meta_we(meta_we),
		.data_we(data_we),
		.meta_wdata(meta_wdata),
		.data_wdata(data_wdata)
	);

endmodule

`default_nettype wire

/* dcache/set_ram.sv */
`timescale 1ns/10ps
`default_nettype none

`include "dcache_defs.svh"

module set_ram #(
	parameter type entry_t = logic
) (
	input logic CLK,
	input logic nRST,
	input logic we,
	input logic [`DC_IDX_W-1:0] widx,
	input logic [`DC_IDX_W-1:0] ridx,
	input entry_t wdata,
	output entry_t rdata
);

	// one entry per set for a single way
	entry_t mem [`DC_SETS];

	always_ff @(posedge CLK, negedge nRST) begin
		if (!nRST) begin
			for (int i = 0; i < `DC_SETS; i++) begin
				mem[i] <= '0;
			end
		end else if (we) begin
			mem[widx] <= wdata;
		end
	end

	// asynchronous read
	assign rdata = mem[ridx];

endmodule

`default_nettype wire

/* dcache/tag_lookup.sv */
`timescale 1ns/10ps
`default_nettype none

`include "dcache_defs.svh"

module tag_lookup (
	input cpu_pkg::dc_addr_t addr,
	input mem_pkg::line_meta_t [`DC_WAYS-1:0] meta,
	input logic lru,
	input logic flushing,
	output logic hit,
	output logic hit_way,
	output logic victim_way,
	output mem_pkg::line_meta_t victim
);

	logic [`DC_WAYS-1:0] match;

	// tag compare against valid lines only
	always_comb begin
		for (int w = 0; w < `DC_WAYS; w++) begin
			match[w] = meta[w].valid && (meta[w].tag == addr.tag);
		end
	end

	assign hit = |match;

	// at most one way matches
	assign hit_way = match[1];

	// invalid ways first, then lru
	// during flush the controller steers the way through lru
	always_comb begin
		if (flushing) begin
			victim_way = lru;
		end else if (!meta[0].valid) begin
			victim_way = 1'b0;
		end else if (!meta[1].valid) begin
			victim_way = 1'b1;
		end else begin
			victim_way = lru;
		end
	end

	assign victim = meta[victim_way];

endmodule

`default_nettype wire

/* dv/dcache_stimulus.txt */
# columns: name op(R/W/H) addr store expected_load expected_first_cycle_hit
# load of a write is the word before the store, unwritten memory holds ~addr
cold_rd     R 00000100 00000000 fffffeff 0
same_blk    R 00000104 00000000 fffffefb 1
wr_hit      W 00000100 cafef00d fffffeff 1
rd_back     R 00000100 00000000 cafef00d 1
lru_fill_a  R 00000050 00000000 ffffffaf 0
lru_fill_b  R 00000090 00000000 ffffff6f 0
lru_touch_a R 00000054 00000000 ffffffab 1
lru_fill_c  R 000000d0 00000000 ffffff2f 0
lru_a_stays R 00000050 00000000 ffffffaf 1
lru_b_gone  R 00000090 00000000 ffffff6f 0
dirty_w0    W 00000028 11112222 ffffffd7 0
dirty_w1    W 0000002c 33334444 ffffffd3 1
evict_fill1 R 00000068 00000000 ffffff97 0
evict_dirty R 000000a8 00000000 ffffff57 0
reread_w0   R 00000028 00000000 11112222 0
reread_w1   R 0000002c 00000000 33334444 1
flush_w_a   W 00000050 5555aaaa ffffffaf 1
flush_w_new W 00000134 77778888 fffffecb 0
halt        H 00000000 00000000 00000000 0

/* dv/dcache_sva.sv */
`timescale 1ns/10ps
`default_nettype none

module dcache_sva (
	input logic CLK,
	input logic nRST,
	input mem_pkg::mem_req_t mreq,
	input mem_pkg::mem_rsp_t mrsp,
	input cpu_pkg::cpu_rsp_t rsp,
	input mem_pkg::ctrl_state_t state
);

	one_strobe: assert property (@(posedge CLK) disable iff (!nRST)
		!(mreq.ren && mreq.wen))
		else $error("memory read and write strobes high together");

	// stall freezes the transfer
	hold_on_stall: assert property (@(posedge CLK) disable iff (!nRST)
		(mreq.ren || mreq.wen) && mrsp.stall |=> $stable(mreq))
		else $error("memory request changed while stalled");

	flushed_sticky: assert property (@(posedge CLK) disable iff (!nRST)
		rsp.flushed |=> rsp.flushed)
		else $error("flushed dropped before reset");

	idle_quiet: assert property (@(posedge CLK) disable iff (!nRST)
		state == mem_pkg::IDLE |-> !mreq.ren && !mreq.wen)
		else $error("memory strobe high in IDLE");

endmodule

bind cache_ctrl dcache_sva u_sva (
	.CLK(CLK),
	.nRST(nRST),
	.mreq(mreq),
	.mrsp(mrsp),
	.rsp(rsp),
	.state(state)
);

`default_nettype wire

/* dv/dcache_tb.sv */
`timescale 1ns/10ps
`default_nettype none

module dcache_tb;

	// one line of the stimulus file
	typedef struct packed {
		logic [8*16-1:0] name;
		logic [7:0] op;
		cpu_pkg::word_t addr;
		cpu_pkg::word_t store;
		cpu_pkg::word_t load;
		logic hit;
	} stim_t;

	logic CLK = 1'b0;
	logic nRST;
	cpu_pkg::cpu_req_t req;
	cpu_pkg::cpu_rsp_t rsp;
	mem_pkg::mem_req_t mreq;
	mem_pkg::mem_rsp_t mrsp = '{stall: 1'b1, load: '0};
	// memory request as seen mid-cycle, away from the clock edge
	mem_pkg::mem_req_t mreq_q = '0;

	stim_t ops[$];
	// last value stored by the processor at each word address
	cpu_pkg::word_t expected_mem [cpu_pkg::word_t];
	cpu_pkg::word_t mem_model [cpu_pkg::word_t];
	integer seed = 21810;
	int stall_left;
	logic busy = 1'b0;
	int watchdog_cycles = 0;

	dcache dut (
		.CLK(CLK),
		.nRST(nRST),
		.req(req),
		.rsp(rsp),
		.mreq(mreq),
		.mrsp(mrsp)
	);

	always #50 CLK = ~CLK;

	function automatic cpu_pkg::word_t read_mem(input cpu_pkg::word_t addr);
		if (mem_model.exists(addr)) begin
			return mem_model[addr];
		end
		// unwritten words hold the complement of their address
		return ~addr;
	endfunction

	always @(negedge CLK) begin
		mreq_q <= mreq;
	end

	// memory model, one lookup cycle then 0 to 3 random stall cycles per word
	always @(posedge CLK) begin
		if (mreq_q.ren || mreq_q.wen) begin
			if (!mrsp.stall) begin
				if (mreq_q.wen) begin
					mem_model[mreq_q.addr] = mreq_q.store;
				end
				busy <= 1'b0;
				mrsp.stall <= 1'b1;
			end else begin
				if (!busy) begin
					busy <= 1'b1;
					stall_left = $unsigned($random(seed)) % 4;
				end else begin
					stall_left = stall_left - 1;
				end
				if (stall_left == 0) begin
					mrsp.stall <= 1'b0;
					mrsp.load <= read_mem(mreq_q.addr);
				end
			end
		end
	end

	task automatic check_word(input string name, input cpu_pkg::word_t expected,
			input cpu_pkg::word_t actual);
		if (actual !== expected) begin
			$display("[FAIL] %s: expected %h, actual %h", name, expected, actual);
			$display("Test failures found");
			$fatal(1, "%s mismatch", name);
		end
	endtask

	task automatic check_flag(input string name, input logic expected, input logic actual);
		if (actual !== expected) begin
			$display("[FAIL] %s: expected %b, actual %b", name, expected, actual);
			$display("Test failures found");
			$fatal(1, "%s mismatch", name);
		end
	endtask

	task automatic read_stimulus();
		int fd;
		int n;
		string line;
		logic [8*16-1:0] name;
		logic [7:0] op;
		cpu_pkg::word_t a;
		cpu_pkg::word_t s;
		cpu_pkg::word_t l;
		logic h;
		fd = $fopen("dv/dcache_stimulus.txt", "r");
		if (fd == 0) begin
			$display("Could not open the stimulus file dv/dcache_stimulus.txt");
			$display("Test failures found");
			$fatal(1, "no stimulus");
		end else begin
			while (!$feof(fd)) begin
				line = "";
				void'($fgets(line, fd));
				if (line.len() > 0 && line.getc(0) != "#") begin
					n = $sscanf(line, "%s %s %h %h %h %b", name, op, a, s, l, h);
					if (n == 6) begin
						ops.push_back('{name: name, op: op, addr: a, store: s, load: l, hit: h});
						if (op == "W") begin
							expected_mem[a] = s;
						end
					end
				end
			end
			$fclose(fd);
		end
	endtask

	// drive one operation and wait for it to complete
	task automatic run_op(input stim_t e);
		string tname;
		logic first_hit;
		tname = $sformatf("%0s", e.name);
		req.ren <= (e.op == "R");
		req.wen <= (e.op == "W");
		req.halt <= (e.op == "H");
		req.addr <= cpu_pkg::dc_addr_t'(e.addr);
		req.store <= e.store;
		@(negedge CLK);
		first_hit = rsp.hit;
		if (e.op == "H") begin
			while (!rsp.flushed) begin
				@(negedge CLK);
			end
		end else begin
			while (!rsp.hit) begin
				@(negedge CLK);
			end
			check_word({tname, " load"}, e.load, rsp.load);
			// request completes at this edge
			@(posedge CLK);
		end
		check_flag({tname, " first-cycle hit"}, e.hit, first_hit);
	endtask

	initial begin
		nRST = 1'b0;
		req = '0;
		read_stimulus();
		watchdog_cycles = ops.size() * 40 + 200 + 12;
		repeat (4) @(posedge CLK);
		nRST <= 1'b1;
		@(negedge CLK);
		check_flag("reset mreq.ren", 1'b0, mreq.ren);
		check_flag("reset mreq.wen", 1'b0, mreq.wen);
		check_flag("reset rsp.hit", 1'b0, rsp.hit);
		check_flag("reset rsp.flushed", 1'b0, rsp.flushed);
		@(posedge CLK);
		foreach (ops[i]) begin
			run_op(ops[i]);
		end
		// every stored word has reached memory once flushed is up
		foreach (expected_mem[a]) begin
			check_word($sformatf("flush mem[%h]", a), expected_mem[a], read_mem(a));
		end
		repeat (8) begin
			@(negedge CLK);
			check_flag("strobes after flush", 1'b0, mreq.ren | mreq.wen);
			check_flag("flushed held", 1'b1, rsp.flushed);
		end
		$display("All tests passed!");
		$finish;
	end

	initial begin
		wait (watchdog_cycles != 0);
		repeat (watchdog_cycles) @(posedge CLK);
		$display("Timeout: the cache did not finish within %0d cycles", watchdog_cycles);
		$display("Test failures found");
		$fatal(1, "watchdog expired");
	end

endmodule

`default_nettype wire

/* run.sh */
#!/bin/sh
# build and run the dcache testbench with Verilator

cd "$(dirname "$0")" || exit 1
LOG=sim.log

verilator --binary --timing --assert -Wno-fatal -j 0 -f tb.f \
	--top-module dcache_tb --Mdir obj_dir -o dcache_sim
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

./obj_dir/dcache_sim > "$LOG" 2>&1
status=$?
cat "$LOG"

if grep -q "Test failures found" "$LOG"; then
	exit 1
fi
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi
exit 0

/* tb.f */
+incdir+common
common/cpu_pkg.sv
common/mem_pkg.sv
dcache/set_ram.sv
dcache/tag_lookup.sv
dcache/cache_ctrl.sv
dcache/dcache.sv
dv/dcache_sva.sv
dv/dcache_tb.sv
